/* compile.f */
+incdir+rtl
rtl/adc_panel_pkg.sv
rtl/i2c_adc_reader.sv
rtl/sample_formatter.sv
rtl/seg_scan.sv
rtl/uart_rx.sv
rtl/adc_panel_top.sv
verif/i2c_adc_model.sv
verif/tb_adc_panel.sv

/* run_sim.sh */
#!/bin/sh
# Builds the panel testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_adc_panel --Mdir obj_dir -o tb_adc_panel -f compile.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_adc_panel > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
	exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
	echo "no result line in sim.log"
	exit 1
fi
exit 0

/* verif/tb_adc_panel.sv */
// Testbench of the ADC sensor panel.
// Drives adc_panel_top with a behavioral I2C ADC and a UART driver, then reads
// the display back through the scan lines and checks every digit.

`default_nettype none

`include "adc_panel_defs.svh"

module tb_adc_panel;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int SCAN_CYCLES = 8 * `ADC_PANEL_SCAN_DIV;
	// one read with gap and handshake slack
	localparam int READ_CYCLES = 4 * `ADC_PANEL_SCL_DIV * 20 + `ADC_PANEL_SAMPLE_GAP + 32;
	localparam int UART_CYCLES = 12 * `ADC_PANEL_BAUD_DIV;
	localparam int RUN_READS   = 2 * 5 + 2 * 10 + 2;
	localparam int RUN_BYTES   = 2 + 10;
	localparam int RUN_SCANS   = 1 + 5 + 2 + 10;
	// waiting for digit0 can cost a second scan
	localparam int CYCLE_LIMIT = 2 * (16 + RUN_READS * READ_CYCLES +
		RUN_BYTES * UART_CYCLES + RUN_SCANS * 2 * SCAN_CYCLES);

	logic                       sys_clk = 1'b0;
	logic                       sys_rst_n;
	logic                       uart_rx_port;
	logic                       scl;
	logic                       sda_in;
	logic                       sda_oe;
	logic [7:0]                 seg_number;
	logic [7:0]                 seg_choice;
	adc_panel_pkg::adc_sample_t adc_value;
	int                         proto_errors;
	int                         xfer_count;

	int                         cycle_count = 0;
	int                         ack_count = 0;
	int                         rx_count = 0;
	logic                       ack_d = 1'b0;
	int                         checks;
	int                         errors;
	// expected state of the panel
	adc_panel_pkg::adc_sample_t adc_now;
	logic                       uart_seen;
	adc_panel_pkg::uart_byte_t  uart_last;
	adc_panel_pkg::seg_glyph_t  shown_glyph [8];
	adc_panel_pkg::seg_glyph_t  want_glyph [8];

	adc_panel_top u_adc_panel_top (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.uart_rx_port (uart_rx_port),
		.scl          (scl),
		.sda_in       (sda_in),
		.sda_oe       (sda_oe),
		.seg_number   (seg_number),
		.seg_choice   (seg_choice)
	);

	i2c_adc_model u_i2c_adc_model (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.scl        (scl),
		.sda_oe     (sda_oe),
		.sda_in     (sda_in),
		.adc_value  (adc_value),
		.err_count  (proto_errors),
		.xfer_count (xfer_count)
	);

	always #20 sys_clk = ~sys_clk;

	// completed handshakes and received bytes
	always @(posedge sys_clk) begin
		ack_d <= u_adc_panel_top.sample_ack;
		if (u_adc_panel_top.sample_ack && !ack_d) begin
			ack_count <= ack_count + 1;
		end
		if (u_adc_panel_top.rx_valid) begin
			rx_count <= rx_count + 1;
		end
	end

	always @(posedge sys_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, the tests did not finish", cycle_count);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// active-low segments with bit 0 as a and bit 7 as the dot
	function automatic adc_panel_pkg::seg_glyph_t decode_segments(input logic [7:0] seg);
		adc_panel_pkg::seg_glyph_t g;
		case (seg)
			8'hc0: g = 5'd0;
			8'hf9: g = 5'd1;
			8'ha4: g = 5'd2;
			8'hb0: g = 5'd3;
			8'h99: g = 5'd4;
			8'h92: g = 5'd5;
			8'h82: g = 5'd6;
			8'hf8: g = 5'd7;
			8'h80: g = 5'd8;
			8'h90: g = 5'd9;
			8'h88: g = 5'd10;
			8'h83: g = 5'd11;
			8'hc6: g = 5'd12;
			8'ha1: g = 5'd13;
			8'h86: g = 5'd14;
			8'h8e: g = 5'd15;
			8'hff: g = 5'd16;
			8'hbf: g = 5'd17;
			// not a valid pattern
			default: g = 5'd31;
		endcase
		return g;
	endfunction

	task automatic build_expected();
		int hund;
		int tens;
		int ones;
		hund = int'(adc_now) / 100;
		tens = (int'(adc_now) / 10) % 10;
		ones = int'(adc_now) % 10;
		want_glyph[7] = adc_panel_pkg::GLYPH_BLANK;
		want_glyph[6] = uart_seen ? 5'(uart_last[7:4]) : adc_panel_pkg::GLYPH_BLANK;
		want_glyph[5] = uart_seen ? 5'(uart_last[3:0]) : adc_panel_pkg::GLYPH_BLANK;
		want_glyph[4] = adc_panel_pkg::GLYPH_DASH;
		want_glyph[3] = adc_panel_pkg::GLYPH_BLANK;
		// leading zeros stay blank but a lone zero shows in digit0
		want_glyph[2] = (hund != 0) ? 5'(hund) : adc_panel_pkg::GLYPH_BLANK;
		want_glyph[1] = (hund != 0 || tens != 0) ? 5'(tens) : adc_panel_pkg::GLYPH_BLANK;
		want_glyph[0] = 5'(ones);
	endtask

	// one full scan starting when digit0 lights
	task automatic capture_scan();
		logic [7:0] prev_choice;
		logic [7:0] want_sel;
		int         d;
		prev_choice = seg_choice;
		@(negedge sys_clk);
		while (!(seg_choice == 8'hfe && prev_choice != 8'hfe)) begin
			prev_choice = seg_choice;
			@(negedge sys_clk);
		end
		shown_glyph[0] = decode_segments(seg_number);
		for (d = 1; d < 8; d++) begin
			want_sel = ~(8'd1 << d);
			while (seg_choice != want_sel) begin
				@(negedge sys_clk);
			end
			shown_glyph[3'(d)] = decode_segments(seg_number);
		end
	endtask

	task automatic check_frame(input string tag);
		int d;
		for (d = 0; d < 8; d++) begin
			checks++;
			assert (shown_glyph[3'(d)] === want_glyph[3'(d)]) else begin
				$display("[ERROR] %0t ns %s digit%0d expected %0d got %0d", $time, tag, d,
					want_glyph[3'(d)], shown_glyph[3'(d)]);
				errors++;
			end
		end
	endtask

	task automatic set_adc_value(input adc_panel_pkg::adc_sample_t v, output int base);
		@(posedge sys_clk);
		adc_value <= v;
		@(negedge sys_clk);
		base    = ack_count;
		adc_now = v;
	endtask

	// the first ack may still carry the old value
	task automatic wait_samples(input int base, input int n);
		while (ack_count < base + n) begin
			@(negedge sys_clk);
		end
	endtask

	task automatic send_uart_byte(input adc_panel_pkg::uart_byte_t b);
		logic [9:0] bits;
		int         i;
		int         base;
		base = rx_count;
		// stop bit, data lsb first and start bit
		bits = {1'b1, b, 1'b0};
		for (i = 0; i < 10; i++) begin
			@(posedge sys_clk);
			uart_rx_port <= bits[0];
			bits = bits >> 1;
			repeat (`ADC_PANEL_BAUD_DIV - 1) @(posedge sys_clk);
		end
		while (rx_count == base) begin
			@(negedge sys_clk);
		end
		uart_seen = 1'b1;
		uart_last = b;
	endtask

	task automatic report_test(input string name, input int start_err);
		$display("[%s] finished, %0d errors", name, errors - start_err);
	endtask

	task automatic reset_idle_check();
		int   start_err;
		int   n;
		logic oe_seen;
		start_err = errors;
		oe_seen   = 1'b0;
		for (n = 0; n < SCAN_CYCLES; n++) begin
			@(negedge sys_clk);
			checks++;
			assert (seg_number == 8'hff) else begin
				$display("[ERROR] %0t ns seg_number expected ff got %h", $time, seg_number);
				errors++;
			end
			if (sda_oe && !oe_seen) begin
				oe_seen = 1'b1;
				checks++;
				// first pull on sda has to be a start after the idle gap
				assert (scl && n >= `ADC_PANEL_SAMPLE_GAP) else begin
					$display("sda pulled low at cycle %0d with scl %b, not a start after the gap",
						n, scl);
					errors++;
				end
			end
		end
		checks++;
		assert (oe_seen) else begin
			$display("no start condition within one scan after reset");
			errors++;
		end
		report_test("reset_idle", start_err);
	endtask

	task automatic adc_value_sweep();
		adc_panel_pkg::adc_sample_t values [5];
		int start_err;
		int i;
		int base;
		values    = '{8'd7, 8'd42, 8'd100, 8'd255, 8'd0};
		start_err = errors;
		for (i = 0; i < 5; i++) begin
			set_adc_value(values[3'(i)], base);
			wait_samples(base, 2);
			build_expected();
			capture_scan();
			check_frame($sformatf("adc %0d", values[3'(i)]));
		end
		report_test("adc_values", start_err);
	endtask

	task automatic uart_field_check();
		int start_err;
		start_err = errors;
		send_uart_byte(8'ha5);
		build_expected();
		capture_scan();
		check_frame("uart a5");
		send_uart_byte(8'h3c);
		build_expected();
		capture_scan();
		check_frame("uart 3c");
		report_test("uart_bytes", start_err);
	endtask

	task automatic random_rounds();
		adc_panel_pkg::adc_sample_t v;
		adc_panel_pkg::uart_byte_t  b;
		int start_err;
		int i;
		int base;
		start_err = errors;
		for (i = 0; i < 10; i++) begin
			v = 8'($urandom_range(255, 0));
			b = 8'($urandom_range(255, 0));
			set_adc_value(v, base);
			send_uart_byte(b);
			wait_samples(base, 2);
			build_expected();
			capture_scan();
			check_frame($sformatf("round %0d adc %0d uart %h", i, v, b));
		end
		report_test("random_rounds", start_err);
	endtask

	task automatic protocol_audit();
		int start_err;
		start_err = errors;
		checks++;
		assert (proto_errors == 0) else begin
			$display("[ERROR] %0t ns proto_errors expected 0 got %0d", $time, proto_errors);
			errors++;
		end
		// every ack comes from a read the model saw complete
		checks++;
		assert (xfer_count > 0 && xfer_count >= ack_count) else begin
			$display("the ADC model saw %0d complete reads but the panel acknowledged %0d",
				xfer_count, ack_count);
			errors++;
		end
		report_test("protocol", start_err);
	endtask

	initial begin
		sys_rst_n    = 1'b0;
		uart_rx_port = 1'b1;
		adc_value    = 8'd0;
		checks       = 0;
		errors       = 0;
		adc_now      = 8'd0;
		uart_seen    = 1'b0;
		uart_last    = 8'd0;
		void'($urandom(32'h994a_7a9c));
		repeat (16) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		reset_idle_check();
		adc_value_sweep();
		uart_field_check();
		random_rounds();
		protocol_audit();
		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verif/i2c_adc_model.sv */
// Behavioral I2C slave standing in for the ADC in the panel testbench.
// Answers read transactions with adc_value and counts protocol errors.
// SDA is resolved here as an open-drain line with a pull-up.

`default_nettype none

`include "adc_panel_defs.svh"

module i2c_adc_model (
	input  logic                       sys_clk,
	input  logic                       sys_rst_n,
	input  logic                       scl,
	input  logic                       sda_oe,
	output logic                       sda_in,
	input  adc_panel_pkg::adc_sample_t adc_value,
	output int                         err_count,
	output int                         xfer_count
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [7:0] READ_ADDR = {`ADC_PANEL_ADC_ADDR, 1'b1};

	logic                       slave_low;
	logic                       sda_line;
	logic                       scl_d;
	logic                       sda_d;
	logic                       in_xfer;
	logic                       addr_ok;
	int                         rise_cnt;
	logic [7:0]                 shift;
	adc_panel_pkg::adc_sample_t tx_data;

	// wired-and of master and slave, pulled up when both release
	assign sda_line = !(sda_oe || slave_low);
	assign sda_in   = sda_line;

	// pulses 1-8 address, 9 ack, 10-17 data, 18 nack, 19 stop setup
	always @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			scl_d      <= 1'b1;
			sda_d      <= 1'b1;
			slave_low  <= 1'b0;
			in_xfer    <= 1'b0;
			addr_ok    <= 1'b0;
			rise_cnt   <= 0;
			shift      <= 8'h00;
			tx_data    <= 8'h00;
			err_count  <= 0;
			xfer_count <= 0;
		end else begin
			scl_d <= scl;
			sda_d <= sda_line;
			if (scl && scl_d && sda_d && !sda_line) begin
				// start condition
				if (in_xfer) begin
					$display("i2c model: start at %0t ns before the previous read stopped", $time);
					err_count <= err_count + 1;
				end
				in_xfer   <= 1'b1;
				rise_cnt  <= 0;
				slave_low <= 1'b0;
			end else if (scl && scl_d && !sda_d && sda_line) begin
				// stop condition
				if (in_xfer && rise_cnt != 19) begin
					$display("i2c model: stop at %0t ns after %0d clock pulses instead of 19",
						$time, rise_cnt);
					err_count <= err_count + 1;
				end else if (in_xfer) begin
					xfer_count <= xfer_count + 1;
				end
				in_xfer   <= 1'b0;
				slave_low <= 1'b0;
			end else if (in_xfer && scl && !scl_d) begin
				rise_cnt <= rise_cnt + 1;
				if (rise_cnt < 8) begin
					shift <= {shift[6:0], sda_line};
				end
				if (rise_cnt == 17 && !sda_line) begin
					$display("i2c model: master acked the data byte at %0t ns, NACK expected", $time);
					err_count <= err_count + 1;
				end
				if (rise_cnt >= 19) begin
					$display("i2c model: extra clock pulse at %0t ns, no stop after the read", $time);
					err_count <= err_count + 1;
				end
			end else if (in_xfer && !scl && scl_d) begin
				if (rise_cnt == 8) begin
					addr_ok   <= (shift == READ_ADDR);
					slave_low <= (shift == READ_ADDR);
					tx_data   <= adc_value;
					if (shift != READ_ADDR) begin
						$display("i2c model: address byte %h at %0t ns, expected %h",
							shift, $time, READ_ADDR);
						err_count <= err_count + 1;
					end
				end else if (rise_cnt >= 9 && rise_cnt <= 16 && addr_ok) begin
					// data goes out msb first
					slave_low <= !tx_data[7];
					tx_data   <= {tx_data[6:0], 1'b0};
				end else begin
					slave_low <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/adc_panel_top.sv */
// Board top of the ADC sensor panel.
// Polls the I2C ADC, shows the value in decimal and the last UART byte in hex.
// SDA is split into sda_in and sda_oe; the board wrapper adds the open-drain pad.

`default_nettype none

module adc_panel_top (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       uart_rx_port,
	output logic       scl,
	input  logic       sda_in,
	output logic       sda_oe,
	output logic [7:0] seg_number,
	output logic [7:0] seg_choice
);

	logic                       sample_req;
	logic                       sample_ack;
	adc_panel_pkg::adc_sample_t sample;
	logic                       rx_valid;
	adc_panel_pkg::uart_byte_t  rx_byte;
	adc_panel_pkg::seg_frame_t  frame;

	i2c_adc_reader u_i2c_adc_reader (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.scl        (scl),
		.sda_in     (sda_in),
		.sda_oe     (sda_oe),
		.sample_req (sample_req),
		.sample     (sample),
		.sample_ack (sample_ack)
	);

	sample_formatter u_sample_formatter (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.sample_req (sample_req),
		.sample     (sample),
		.sample_ack (sample_ack),
		.rx_valid   (rx_valid),
		.rx_byte    (rx_byte),
		.frame      (frame)
	);

	seg_scan u_seg_scan (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.frame      (frame),
		.seg_number (seg_number),
		.seg_choice (seg_choice)
	);

	uart_rx u_uart_rx (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.uart_rx_port (uart_rx_port),
		.rx_valid     (rx_valid),
		.rx_byte      (rx_byte)
	);

endmodule

`default_nettype wire

/* rtl/uart_rx.sv */
// 8N1 UART receiver with mid-bit sampling.
// rx_valid pulses for one clock about half a bit after the middle of a good stop bit.

`default_nettype none

`include "adc_panel_defs.svh"

module uart_rx (
	input  logic                      sys_clk,
	input  logic                      sys_rst_n,
	input  logic                      uart_rx_port,
	output logic                      rx_valid,
	output adc_panel_pkg::uart_byte_t rx_byte
);

	localparam int BAUD_W = $clog2(`ADC_PANEL_BAUD_DIV + 1);
	localparam logic [BAUD_W-1:0] FULL_BIT = BAUD_W'(`ADC_PANEL_BAUD_DIV - 1);
	localparam logic [BAUD_W-1:0] HALF_BIT = BAUD_W'(`ADC_PANEL_BAUD_DIV / 2 - 1);

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP,
		RX_TAIL
	} rx_state_t;

	rx_state_t                 state;
	logic                      rx_meta;
	logic                      rx_sync;
	logic [BAUD_W-1:0]         baud_cnt;
	logic [2:0]                bit_cnt;
	adc_panel_pkg::uart_byte_t shift;

	// two-stage synchronizer, line idles high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= uart_rx_port;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= RX_IDLE;
			baud_cnt <= '0;
			bit_cnt  <= 3'd0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			baud_cnt <= baud_cnt + 1'b1;
			case (state)
				RX_IDLE: begin
					baud_cnt <= '0;
					if (!rx_sync) begin
						state <= RX_START;
					end
				end
				RX_START: begin
					// glitch filter: start must still be low at mid-bit
					if (baud_cnt == HALF_BIT) begin
						baud_cnt <= '0;
						bit_cnt  <= 3'd0;
						state    <= rx_sync ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA: begin
					if (baud_cnt == FULL_BIT) begin
						baud_cnt <= '0;
						bit_cnt  <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7) begin
							state <= RX_STOP;
						end
					end
				end
				RX_STOP: begin
					if (baud_cnt == FULL_BIT) begin
						baud_cnt <= '0;
						// framing error drops the byte
						state    <= rx_sync ? RX_TAIL : RX_IDLE;
					end
				end
				RX_TAIL: begin
					if (baud_cnt == HALF_BIT) begin
						rx_valid <= 1'b1;
						state    <= RX_IDLE;
					end
				end
				default: begin
					state <= RX_IDLE;
				end
			endcase
		end
	end

	// lsb first
	always_ff @(posedge sys_clk) begin
		if (state == RX_DATA && baud_cnt == FULL_BIT) begin
			shift <= {rx_sync, shift[7:1]};
		end
		if (state == RX_TAIL && baud_cnt == HALF_BIT) begin
			rx_byte <= shift;
		end
	end

endmodule

`default_nettype wire

/* rtl/seg_scan.sv */
// Multiplexes the eight-digit frame onto the seven-segment display.
// Segments and digit selects are active low; bit 0 is segment a, bit 7 the unused dot.

`default_nettype none

`include "adc_panel_defs.svh"

module seg_scan (
	input  logic                      sys_clk,
	input  logic                      sys_rst_n,
	input  adc_panel_pkg::seg_frame_t frame,
	output logic [7:0]                seg_number,
	output logic [7:0]                seg_choice
);

	localparam int SCAN_W = $clog2(`ADC_PANEL_SCAN_DIV + 1);

	logic [SCAN_W-1:0]         scan_cnt;
	logic [2:0]                digit_idx;
	adc_panel_pkg::seg_glyph_t glyph;
	// active-high g..a pattern
	logic [6:0]                seg_on;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			scan_cnt  <= '0;
			digit_idx <= 3'd0;
		end else if (scan_cnt == SCAN_W'(`ADC_PANEL_SCAN_DIV - 1)) begin
			scan_cnt  <= '0;
			digit_idx <= digit_idx + 1'b1;
		end else begin
			scan_cnt <= scan_cnt + 1'b1;
		end
	end

	always_comb begin
		case (digit_idx)
			3'd0: glyph = frame.digit0;
			3'd1: glyph = frame.digit1;
			3'd2: glyph = frame.digit2;
			3'd3: glyph = frame.digit3;
			3'd4: glyph = frame.digit4;
			3'd5: glyph = frame.digit5;
			3'd6: glyph = frame.digit6;
			default: glyph = frame.digit7;
		endcase
	end

	always_comb begin
		case (glyph)
			5'd0:  seg_on = 7'h3f;
			5'd1:  seg_on = 7'h06;
			5'd2:  seg_on = 7'h5b;
			5'd3:  seg_on = 7'h4f;
			5'd4:  seg_on = 7'h66;
			5'd5:  seg_on = 7'h6d;
			5'd6:  seg_on = 7'h7d;
			5'd7:  seg_on = 7'h07;
			5'd8:  seg_on = 7'h7f;
			5'd9:  seg_on = 7'h6f;
			5'd10: seg_on = 7'h77;
			5'd11: seg_on = 7'h7c;
			5'd12: seg_on = 7'h39;
			5'd13: seg_on = 7'h5e;
			5'd14: seg_on = 7'h79;
			5'd15: seg_on = 7'h71;
			// dash lights g only
			5'd17: seg_on = 7'h40;
			default: seg_on = 7'h00;
		endcase
	end

	// registered outputs, all off until the first step after reset
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			seg_number <= 8'hff;
			seg_choice <= 8'hff;
		end else begin
			seg_number <= {1'b1, ~seg_on};
			seg_choice <= ~(8'd1 << digit_idx);
		end
	end

endmodule

`default_nettype wire

/* rtl/sample_formatter.sv */
// Builds the display frame from ADC samples and received UART bytes.
// Samples become three decimal digits with leading blanks; the UART byte shows as hex.

`default_nettype none

module sample_formatter (
	input  logic                       sys_clk,
	input  logic                       sys_rst_n,
	input  logic                       sample_req,
	input  adc_panel_pkg::adc_sample_t sample,
	output logic                       sample_ack,
	input  logic                       rx_valid,
	input  adc_panel_pkg::uart_byte_t  rx_byte,
	output adc_panel_pkg::seg_frame_t  frame
);

	typedef enum logic [2:0] {
		FMT_IDLE,
		FMT_HUND,
		FMT_TENS,
		FMT_WRITE,
		FMT_ACK
	} fmt_state_t;

	fmt_state_t                 state;
	logic                       req_d;
	adc_panel_pkg::adc_sample_t rem;
	logic [1:0]                 hund;
	logic [3:0]                 tens;
	adc_panel_pkg::seg_glyph_t  glyph2;
	adc_panel_pkg::seg_glyph_t  glyph1;

	// leading zero suppression
	assign glyph2 = (hund != 2'd0) ? adc_panel_pkg::seg_glyph_t'(hund) : adc_panel_pkg::GLYPH_BLANK;
	assign glyph1 = (hund != 2'd0 || tens != 4'd0) ?
		adc_panel_pkg::seg_glyph_t'(tens) : adc_panel_pkg::GLYPH_BLANK;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state      <= FMT_IDLE;
			req_d      <= 1'b0;
			sample_ack <= 1'b0;
			frame      <= {8{adc_panel_pkg::GLYPH_BLANK}};
		end else begin
			req_d <= sample_req;
			// uart field updates even in the middle of a conversion
			if (rx_valid) begin
				frame.digit6 <= adc_panel_pkg::seg_glyph_t'(rx_byte[7:4]);
				frame.digit5 <= adc_panel_pkg::seg_glyph_t'(rx_byte[3:0]);
			end
			case (state)
				FMT_IDLE: begin
					if (sample_req && !req_d) begin
						state <= FMT_HUND;
					end
				end
				FMT_HUND: begin
					if (rem < 8'd100) begin
						state <= FMT_TENS;
					end
				end
				FMT_TENS: begin
					if (rem < 8'd10) begin
						state <= FMT_WRITE;
					end
				end
				FMT_WRITE: begin
					frame.digit4 <= adc_panel_pkg::GLYPH_DASH;
					frame.digit2 <= glyph2;
					frame.digit1 <= glyph1;
					frame.digit0 <= adc_panel_pkg::seg_glyph_t'(rem[3:0]);
					sample_ack   <= 1'b1;
					state        <= FMT_ACK;
				end
				FMT_ACK: begin
					if (!sample_req) begin
						sample_ack <= 1'b0;
						state      <= FMT_IDLE;
					end
				end
				default: begin
					state <= FMT_IDLE;
				end
			endcase
		end
	end

	// repeated subtraction, at most 2 hundreds and 9 tens steps
	always_ff @(posedge sys_clk) begin
		case (state)
			FMT_IDLE: begin
				rem  <= sample;
				hund <= 2'd0;
				tens <= 4'd0;
			end
			FMT_HUND: begin
				if (rem >= 8'd100) begin
					rem  <= rem - 8'd100;
					hund <= hund + 1'b1;
				end
			end
			FMT_TENS: begin
				if (rem >= 8'd10) begin
					rem  <= rem - 8'd10;
					tens <= tens + 1'b1;
				end
			end
			default: begin
				rem <= rem;
			end
		endcase
	end

endmodule

`default_nettype wire

/* rtl/i2c_adc_reader.sv */
// I2C master that keeps reading one byte from the ADC.
// Each good read is offered to the formatter with a four-phase req/ack handshake.
// sda_oe high pulls SDA low; the board wrapper adds the tristate buffer.

`default_nettype none

`include "adc_panel_defs.svh"

module i2c_adc_reader (
	input  logic                       sys_clk,
	input  logic                       sys_rst_n,
	output logic                       scl,
	input  logic                       sda_in,
	output logic                       sda_oe,
	output logic                       sample_req,
	output adc_panel_pkg::adc_sample_t sample,
	input  logic                       sample_ack
);

	localparam int DIV_W = $clog2(`ADC_PANEL_SCL_DIV + 1);
	localparam int GAP_W = $clog2(`ADC_PANEL_SAMPLE_GAP + 1);
	// address with the read bit set
	localparam logic [7:0] ADDR_BYTE = {`ADC_PANEL_ADC_ADDR, 1'b1};

	adc_panel_pkg::i2c_state_t  state;
	logic [DIV_W-1:0]           div_cnt;
	logic [GAP_W-1:0]           gap_cnt;
	logic [1:0]                 quarter;
	logic [2:0]                 bit_cnt;
	logic                       busy;
	logic                       tick;
	logic                       scl_high;
	logic                       ack_ok;
	adc_panel_pkg::adc_sample_t shift_in;
	logic                       scl_next;
	logic                       oe_next;

	// bus phases only run outside idle and handshake
	assign busy = (state != adc_panel_pkg::I2C_IDLE) &&
		(state != adc_panel_pkg::I2C_HANDSHAKE);
	assign tick = busy && (div_cnt == DIV_W'(`ADC_PANEL_SCL_DIV - 1));
	// scl is high in the two middle quarters of a bit
	assign scl_high = (quarter == 2'd1) || (quarter == 2'd2);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			div_cnt <= '0;
		end else if (!busy || tick) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state      <= adc_panel_pkg::I2C_IDLE;
			gap_cnt    <= '0;
			quarter    <= 2'd0;
			bit_cnt    <= 3'd0;
			ack_ok     <= 1'b0;
			sample_req <= 1'b0;
		end else if (state == adc_panel_pkg::I2C_IDLE) begin
			// back-pressure: the gap only runs once ack is low
			if (sample_ack) begin
				gap_cnt <= '0;
			end else if (gap_cnt == GAP_W'(`ADC_PANEL_SAMPLE_GAP)) begin
				gap_cnt <= '0;
				quarter <= 2'd0;
				state   <= adc_panel_pkg::I2C_START;
			end else begin
				gap_cnt <= gap_cnt + 1'b1;
			end
		end else if (state == adc_panel_pkg::I2C_HANDSHAKE) begin
			if (sample_ack) begin
				sample_req <= 1'b0;
				state      <= adc_panel_pkg::I2C_IDLE;
			end
		end else if (tick) begin
			quarter <= quarter + 1'b1;
			case (state)
				adc_panel_pkg::I2C_START: begin
					if (quarter == 2'd3) begin
						bit_cnt <= 3'd0;
						state   <= adc_panel_pkg::I2C_ADDR;
					end
				end
				adc_panel_pkg::I2C_ADDR: begin
					if (quarter == 2'd3) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7) begin
							state <= adc_panel_pkg::I2C_ADDR_ACK;
						end
					end
				end
				adc_panel_pkg::I2C_ADDR_ACK: begin
					if (quarter == 2'd1) begin
						ack_ok <= !sda_in;
					end else if (quarter == 2'd3) begin
						// no ack: abandon the read and just stop
						state <= ack_ok ? adc_panel_pkg::I2C_DATA : adc_panel_pkg::I2C_STOP;
					end
				end
				adc_panel_pkg::I2C_DATA: begin
					if (quarter == 2'd3) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7) begin
							state <= adc_panel_pkg::I2C_NACK;
						end
					end
				end
				adc_panel_pkg::I2C_NACK: begin
					if (quarter == 2'd3) begin
						state <= adc_panel_pkg::I2C_STOP;
					end
				end
				adc_panel_pkg::I2C_STOP: begin
					if (quarter == 2'd3) begin
						if (ack_ok) begin
							sample_req <= 1'b1;
							state      <= adc_panel_pkg::I2C_HANDSHAKE;
						end else begin
							state <= adc_panel_pkg::I2C_IDLE;
						end
					end
				end
				default: begin
					state <= adc_panel_pkg::I2C_IDLE;
				end
			endcase
		end
	end

	// data bits arrive MSB first, sampled mid-way through scl high
	always_ff @(posedge sys_clk) begin
		if (tick && quarter == 2'd1 && state == adc_panel_pkg::I2C_DATA) begin
			shift_in <= {shift_in[6:0], sda_in};
		end
		if (tick && quarter == 2'd3 && state == adc_panel_pkg::I2C_STOP && ack_ok) begin
			sample <= shift_in;
		end
	end

	// sda only moves while scl is low, except for start and stop
	always_comb begin
		scl_next = 1'b1;
		oe_next  = 1'b0;
		case (state)
			adc_panel_pkg::I2C_START: begin
				scl_next = (quarter != 2'd3);
				oe_next  = (quarter != 2'd0);
			end
			adc_panel_pkg::I2C_ADDR: begin
				scl_next = scl_high;
				oe_next  = !ADDR_BYTE[3'd7 - bit_cnt];
			end
			adc_panel_pkg::I2C_ADDR_ACK, adc_panel_pkg::I2C_DATA, adc_panel_pkg::I2C_NACK: begin
				scl_next = scl_high;
			end
			adc_panel_pkg::I2C_STOP: begin
				scl_next = (quarter != 2'd0);
				oe_next  = (quarter < 2'd2);
			end
			default: begin
				scl_next = 1'b1;
				oe_next  = 1'b0;
			end
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			scl    <= 1'b1;
			sda_oe <= 1'b0;
		end else begin
			scl    <= scl_next;
			sda_oe <= oe_next;
		end
	end

endmodule

`default_nettype wire

/* rtl/adc_panel_pkg.sv */
// Shared types of the ADC sensor panel.
// Modules refer to these by scoped name.

`default_nettype none

package adc_panel_pkg;

	typedef logic [7:0] adc_sample_t;
	typedef logic [7:0] uart_byte_t;

	// 0-15 hex digits, 16 blank, 17 dash
	typedef logic [4:0] seg_glyph_t;

	localparam seg_glyph_t GLYPH_BLANK = 5'd16;
	localparam seg_glyph_t GLYPH_DASH  = 5'd17;

	// digit7 is the leftmost digit, digit0 the rightmost
	typedef struct packed {
		seg_glyph_t digit7;
		seg_glyph_t digit6;
		seg_glyph_t digit5;
		seg_glyph_t digit4;
		seg_glyph_t digit3;
		seg_glyph_t digit2;
		seg_glyph_t digit1;
		seg_glyph_t digit0;
	} seg_frame_t;

	typedef enum logic [2:0] {
		I2C_IDLE,
		I2C_START,
		I2C_ADDR,
		I2C_ADDR_ACK,
		I2C_DATA,
		I2C_NACK,
		I2C_STOP,
		I2C_HANDSHAKE
	} i2c_state_t;

endpackage

`default_nettype wire

/* rtl/adc_panel_defs.svh */
// Timing and address constants for the ADC sensor panel.
// Included by every RTL module that needs a divider, a period or the ADC address.
// The values below are sized for simulation; scale them up for the board clock.

`ifndef ADC_PANEL_DEFS_SVH
`define ADC_PANEL_DEFS_SVH

// system clocks per quarter of an SCL period
`define ADC_PANEL_SCL_DIV 8

// system clocks per UART bit
`define ADC_PANEL_BAUD_DIV 16

// clocks each display digit stays lit
`define ADC_PANEL_SCAN_DIV 32

// idle clocks between two ADC reads
`define ADC_PANEL_SAMPLE_GAP 64

// 7-bit I2C address of the ADC
`define ADC_PANEL_ADC_ADDR 7'h54

`endif
